// File: rtl/aurora_tx_pkg.sv
`default_nettype none

package aurora_tx_pkg;

    //////////////////////
    // Packet geometry
    //////////////////////

    localparam int WORD_BITS         = 32;                        // One Aurora lane per beat
    localparam int PACKET_WORDS      = 8;
    localparam int PACKET_BITS       = WORD_BITS * PACKET_WORDS;  // 256 bit FIFO entry
    localparam int MAX_PAYLOAD_WORDS = PACKET_WORDS - 2;          // Two header words precede payload
    localparam int WORD_CNT_BITS     = $clog2(PACKET_WORDS);
    localparam int SEQ_BITS          = 8;

    // Bit positions inside the packet, counted from the top word
    localparam int BUS_ID_MSB = PACKET_BITS - 1;                  // Bus id byte, replaced on the link
    localparam int SRC_ID_MSB = BUS_ID_MSB - SEQ_BITS;            // Id of the FPGA that built the packet
    localparam int LEN_MSB    = PACKET_BITS - 49;                 // Valid byte count sits in 207:192
    localparam int LEN_LSB    = PACKET_BITS - 62;                 // Two low bits skipped, count is words
    localparam int LEN_BITS   = LEN_MSB - LEN_LSB + 1;

    // Board at the far end of the link, broadcast packets from it are not echoed back
    localparam logic [7:0] TARGET_FPGA_ID = 8'h00;

    //////////////////////
    // Control types
    //////////////////////

    typedef enum logic [3:0] {
        RESET,
        IDLE,
        READ,
        CHECK,
        DISCARD,
        HEAD,
        SECOND,
        BODY,
        LAST
    } tx_state_e;

    typedef struct packed {
        logic load;         // Capture dout into the packet register
        logic shift;        // Move the next word to the top
        logic count_en;     // Count one word sent
        logic clear;        // Empty the packet and header registers
        logic stamp_sel;    // Sequence number replaces the bus id byte
        logic seq_advance;  // Packet finished, bump the sequence number
        logic rd_en_next;
        logic tvalid_next;
        logic tlast_next;
    } tx_ctrl_t;

    typedef struct packed {
        logic drop;    // Echoed broadcast or empty packet
        logic single;  // Only one payload word
        logic last;    // Word counter has reached the length
    } hdr_status_t;

endpackage

`default_nettype wire

// File: rtl/tx_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_sequencer
    import aurora_tx_pkg::*;
(
    input  wire logic        user_clk,
    input  wire logic        reset_TX_RX_Block,
    input  wire logic        empty,
    input  wire logic        s_axi_tx_tready,
    input  wire hdr_status_t status,
    output tx_ctrl_t         ctrl,
    output logic             rd_en,
    output logic             s_axi_tx_tvalid,
    output logic             s_axi_tx_tlast
);

    tx_state_e state_q;
    tx_state_e state_d;
    logic      empty_q;  // Inputs are registered to ease timing on the link side
    logic      ready_q;

    ////////////////////
    // Input and output flops
    ////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            empty_q         <= 1'b1;  // Treat the FIFO as empty until sampled
            ready_q         <= 1'b0;
            rd_en           <= 1'b0;
            s_axi_tx_tvalid <= 1'b0;
            s_axi_tx_tlast  <= 1'b0;
            state_q         <= RESET;
        end else begin
            empty_q         <= empty;
            ready_q         <= s_axi_tx_tready;
            rd_en           <= ctrl.rd_en_next;
            s_axi_tx_tvalid <= ctrl.tvalid_next;
            s_axi_tx_tlast  <= ctrl.tlast_next;
            state_q         <= state_d;
        end
    end

    ////////////////////
    // Next state and commands
    ////////////////////

    always_comb begin
        state_d = state_q;
        ctrl    = '0;
        case (state_q)
            RESET: begin
                ctrl.clear = 1'b1;
                state_d    = IDLE;
            end
            IDLE: begin
                ctrl.clear = 1'b1;                     // Header registers wait empty
                if (ready_q && !empty_q) begin         // Ready is only looked at here
                    ctrl.rd_en_next = 1'b1;            // Pop lands on the same edge as the load
                    state_d         = READ;
                end
            end
            READ: begin
                ctrl.load      = 1'b1;
                ctrl.stamp_sel = 1'b1;
                state_d        = CHECK;
            end
            CHECK: begin
                // Keep the stamp request one more cycle so it lines up with HEAD
                ctrl.stamp_sel = 1'b1;
                state_d        = status.drop ? DISCARD : HEAD;
            end
            DISCARD: begin
                ctrl.clear = 1'b1;  // Packet is thrown away, sequence number untouched
                state_d    = IDLE;
            end
            HEAD, SECOND, BODY: begin
                ctrl.shift       = 1'b1;
                ctrl.count_en    = 1'b1;
                ctrl.tvalid_next = 1'b1;  // No back-pressure once the burst has started
                if (state_q == HEAD) begin
                    state_d = SECOND;
                end else if (state_q == SECOND) begin
                    state_d = status.single ? LAST : BODY;
                end else if (status.last) begin
                    state_d = LAST;
                end
            end
            LAST: begin
                ctrl.tvalid_next = 1'b1;
                ctrl.tlast_next  = 1'b1;
                ctrl.seq_advance = 1'b1;  // Only sent packets consume a sequence number
                ctrl.clear       = 1'b1;
                state_d          = IDLE;
            end
            default: begin
                state_d = RESET;
            end
        endcase
    end

    // The encoding has spare codes, none of them may ever be reached
    a_state_legal: assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        state_q inside {RESET, IDLE, READ, CHECK, DISCARD, HEAD, SECOND, BODY, LAST});

    // Exactly one pop per packet
    a_rd_en_pulse: assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        rd_en |=> !rd_en);

endmodule

`default_nettype wire

// File: rtl/packet_header_regs.sv
`timescale 1ns/1ps
`default_nettype none

module packet_header_regs
    import aurora_tx_pkg::*;
(
    input  wire logic                   user_clk,
    input  wire logic                   reset_TX_RX_Block,
    input  wire tx_ctrl_t               ctrl,
    input  wire logic [PACKET_BITS-1:0] packet,
    output hdr_status_t                 status
);

    logic                     load_q;      // Packet register holds the new packet when set
    logic [LEN_BITS-1:0]      len_q;       // Payload words of the packet in flight
    logic [WORD_CNT_BITS-1:0] word_cnt_q;  // Words sent so far, header included

    ////////////////////
    // Length latch
    ////////////////////

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            load_q <= 1'b0;
        end else begin
            load_q <= ctrl.load;  // Length is taken from the register, so wait for the load
        end
    end

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block || ctrl.clear) begin
            len_q <= '0;
        end else if (load_q) begin
            len_q <= packet[LEN_MSB:LEN_LSB];  // Byte count already divided by four
        end
    end

    // Counter runs from the first header word on
    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block || ctrl.clear) begin
            word_cnt_q <= '0;
        end else if (ctrl.count_en) begin
            word_cnt_q <= word_cnt_q + 1'b1;
        end
    end

    // Drop uses the register directly since the latch is not ready in CHECK
    assign status.drop   = (packet[SRC_ID_MSB -: $bits(TARGET_FPGA_ID)] == TARGET_FPGA_ID) ||
                           (packet[LEN_MSB:LEN_LSB] == '0);
    assign status.single = (len_q == LEN_BITS'(1));
    assign status.last   = (LEN_BITS'(word_cnt_q) == len_q);  // Two header words absorb the lag

    // A longer length would let the counter wrap and hang the burst
    a_len_range: assert property (@(posedge user_clk) disable iff (reset_TX_RX_Block)
        load_q |=> (len_q <= MAX_PAYLOAD_WORDS));

endmodule

`default_nettype wire

// File: rtl/payload_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module payload_serializer
    import aurora_tx_pkg::*;
(
    input  wire logic                   user_clk,
    input  wire logic                   reset_TX_RX_Block,
    input  wire tx_ctrl_t               ctrl,
    input  wire logic [PACKET_BITS-1:0] dout,
    output logic [PACKET_BITS-1:0]      packet,
    output logic [WORD_BITS-1:0]        s_axi_tx_tdata
);

    logic [PACKET_BITS-1:0] pkt_q;     // Word to send next is always at the top
    logic [SEQ_BITS-1:0]    seq_q;
    logic                   stamp_q;   // Stamp request delayed to match the output flop
    logic [SEQ_BITS-1:0]    top_byte;

    ////////////////////
    // Packet shift register
    ////////////////////

    // Cleared through ctrl.clear, which the sequencer holds during reset
    always_ff @(posedge user_clk) begin
        if (ctrl.clear) begin
            pkt_q <= '0;
        end else if (ctrl.load) begin
            pkt_q <= dout;
        end else if (ctrl.shift) begin
            pkt_q <= {pkt_q[PACKET_BITS-WORD_BITS-1:0], {WORD_BITS{1'b0}}};  // Zero fill from below
        end
    end

    assign packet = pkt_q;

    ////////////////////
    // Sequence stamping
    ////////////////////

    // Receiver expects 0, 1, 2 and so on, a gap shows a lost packet
    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            seq_q   <= '0;
            stamp_q <= 1'b0;
        end else begin
            stamp_q <= ctrl.stamp_sel;
            if (ctrl.seq_advance) begin
                seq_q <= seq_q + 1'b1;  // Wraps from 255 back to 0
            end
        end
    end

    // The bus id only matters inside the FPGA, so the link carries the sequence instead
    assign top_byte = stamp_q ? seq_q : pkt_q[BUS_ID_MSB -: SEQ_BITS];

    always_ff @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            s_axi_tx_tdata <= '0;
        end else begin
            s_axi_tx_tdata <= {top_byte, pkt_q[BUS_ID_MSB-SEQ_BITS -: WORD_BITS-SEQ_BITS]};
        end
    end

endmodule

`default_nettype wire

// File: rtl/aurora_tx_top.sv
`timescale 1ns/1ps
`default_nettype none

// FIFO to Aurora TX bridge, one 256 bit packet becomes a burst of 32 bit words
module aurora_tx_top
    import aurora_tx_pkg::*;
(
    input  wire logic                   user_clk,
    input  wire logic                   reset_TX_RX_Block,
    input  wire logic                   empty,             // Show-ahead FIFO status
    input  wire logic [PACKET_BITS-1:0] dout,              // Head packet, valid while not empty
    input  wire logic                   s_axi_tx_tready,
    output wire logic                   rd_en,
    output wire logic [WORD_BITS-1:0]   s_axi_tx_tdata,
    output wire logic                   s_axi_tx_tvalid,
    output wire logic                   s_axi_tx_tlast
);

    tx_ctrl_t               ctrl;    // Commands from the sequencer
    hdr_status_t            status;  // Decisions taken on the captured packet
    logic [PACKET_BITS-1:0] packet;  // Raw packet register, header fields are read from it

    // State machine, owns the FIFO pop and the stream flags
    tx_sequencer u_sequencer (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .empty             (empty),
        .s_axi_tx_tready   (s_axi_tx_tready),
        .status            (status),
        .ctrl              (ctrl),
        .rd_en             (rd_en),
        .s_axi_tx_tvalid   (s_axi_tx_tvalid),
        .s_axi_tx_tlast    (s_axi_tx_tlast)
    );

    // Length latch, drop rule and word counter
    packet_header_regs u_header (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .ctrl              (ctrl),
        .packet            (packet),
        .status            (status)
    );

    // Shift register and sequence stamping on the data path
    payload_serializer u_serializer (
        .user_clk          (user_clk),
        .reset_TX_RX_Block (reset_TX_RX_Block),
        .ctrl              (ctrl),
        .dout              (dout),
        .packet            (packet),
        .s_axi_tx_tdata    (s_axi_tx_tdata)
    );

endmodule

`default_nettype wire

// File: tests/tx_checker.sv
`timescale 1ns/1ps
`default_nettype none

// Watches the FIFO pop and the Aurora stream and predicts every beat from the popped packet
module tx_checker
    import aurora_tx_pkg::*;
(
    input  wire logic                   user_clk,
    input  wire logic                   reset_TX_RX_Block,
    input  wire logic                   rd_en,
    input  wire logic [PACKET_BITS-1:0] dout,
    input  wire logic [WORD_BITS-1:0]   s_axi_tx_tdata,
    input  wire logic                   s_axi_tx_tvalid,
    input  wire logic                   s_axi_tx_tlast,
    output int                          errors,
    output int                          sent,
    output int                          dropped,
    output int                          beats,
    output logic                        busy
);

    logic [WORD_BITS-1:0] exp_q[$];    // Beats still owed by the packet in flight
    logic [SEQ_BITS-1:0]  seq_model;   // Counts sent packets only
    logic [SEQ_BITS-1:0]  pkt_seq;
    logic [LEN_BITS-1:0]  len;
    logic [WORD_BITS-1:0] word;
    logic                 seen_pop;    // Outputs must stay quiet until the first pop
    int                   cycle;
    int                   start_cycle; // Posedge where the first beat is due
    int                   pkt_idx;
    int                   beat_idx;
    int                   pkt_errors;

    task finish_packet();
        sent++;
        errors += pkt_errors;
        $display("Packet %0d sent with seq %0d, %0d beats: %s",
                 pkt_idx - 1, pkt_seq, beat_idx, (pkt_errors == 0) ? "ok" : "mismatch");
    endtask

    ////////////////////
    // Beat comparison
    ////////////////////

    always @(posedge user_clk) begin
        if (reset_TX_RX_Block) begin
            exp_q.delete();
            seq_model = '0;
            seen_pop  = 1'b0;
            cycle     = 0;
            pkt_idx   = 0;
            errors    = 0;
            sent      = 0;
            dropped   = 0;
            beats     = 0;
            busy      = 1'b0;
        end else begin
            cycle++;
            if (!seen_pop && (s_axi_tx_tvalid || s_axi_tx_tlast || s_axi_tx_tdata != '0)) begin
                $display("Fail at %0t: stream outputs not idle before the first packet", $time);
                errors++;
            end
            if (s_axi_tx_tvalid) begin
                if (exp_q.size() == 0) begin
                    $display("Extra beat at %0t: tvalid high with no packet in flight", $time);
                    errors++;
                end else begin
                    if (beat_idx == 0 && cycle != start_cycle) begin
                        $display("Packet %0d: first tvalid came %0d cycles after rd_en, not 3",
                                 pkt_idx - 1, cycle - start_cycle + 3);
                        pkt_errors++;
                    end
                    // tlast belongs on the final beat and nowhere else
                    if (s_axi_tx_tdata !== exp_q[0] ||
                        s_axi_tx_tlast !== (exp_q.size() == 1)) begin
                        $display("Fail at %0t: packet %0d beat %0d got %h tlast %b, expected %h",
                                 $time, pkt_idx - 1, beat_idx, s_axi_tx_tdata,
                                 s_axi_tx_tlast, exp_q[0]);
                        pkt_errors++;
                    end
                    void'(exp_q.pop_front());
                    beat_idx++;
                    beats++;
                    if (exp_q.size() == 0) finish_packet();
                end
            end else begin
                if (s_axi_tx_tlast) begin
                    $display("Fail at %0t: tlast high while tvalid is low", $time);
                    errors++;
                end
                if (exp_q.size() != 0 && cycle >= start_cycle) begin
                    $display("Packet %0d: beat %0d is missing, tvalid fell before the burst ended",
                             pkt_idx - 1, beat_idx);
                    pkt_errors++;
                    exp_q.delete();
                    finish_packet();
                end
            end

            ////////////////////
            // Prediction on pop
            ////////////////////

            if (rd_en) begin
                seen_pop = 1'b1;
                pkt_idx++;
                if (exp_q.size() != 0) begin
                    $display("Packet %0d was popped while the previous one was still sending",
                             pkt_idx - 1);
                    errors++;
                    exp_q.delete();
                end
                len = dout[LEN_MSB:LEN_LSB];  // Length counts payload words only
                if (dout[SRC_ID_MSB -: 8] == TARGET_FPGA_ID || len == '0) begin
                    dropped++;
                    $display("Packet %0d dropped, source id %h, length %0d",
                             pkt_idx - 1, dout[SRC_ID_MSB -: 8], len);
                end else begin
                    for (int i = 0; i < int'(len) + 2; i++) begin
                        word = dout[PACKET_BITS-1-WORD_BITS*i -: WORD_BITS];
                        if (i == 0) word[WORD_BITS-1 -: SEQ_BITS] = seq_model;  // Bus id swapped
                        exp_q.push_back(word);
                    end
                    start_cycle = cycle + 3;
                    beat_idx    = 0;
                    pkt_errors  = 0;
                    pkt_seq     = seq_model;
                    seq_model++;  // Wraps 255 to 0 like the link counter
                end
            end
            busy = (exp_q.size() != 0);
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_aurora_tx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_aurora_tx
    import aurora_tx_pkg::*;
;

    localparam int DIRECTED     = 8;
    localparam int RANDOM       = 300;  // Enough sent packets to wrap the sequence number
    localparam int TOTAL        = DIRECTED + RANDOM;
    localparam int RESET_CYCLES = 10;
    localparam int CLK_NS       = 4;
    localparam int WATCHDOG_NS  = (TOTAL * 20 + RESET_CYCLES) * CLK_NS;

    // One table row, expected beat count is zero for a packet that must be dropped
    typedef struct packed {
        logic [7:0]          bus_id;
        logic [7:0]          src_id;
        logic [LEN_BITS-1:0] len;
        logic                ready_low;
        logic [3:0]          beats;
    } stim_t;

    logic                   user_clk = 1'b0;
    logic                   reset_TX_RX_Block;
    logic                   empty;
    logic [PACKET_BITS-1:0] dout;
    logic                   s_axi_tx_tready;
    logic                   rd_en;
    logic [WORD_BITS-1:0]   s_axi_tx_tdata;
    logic                   s_axi_tx_tvalid;
    logic                   s_axi_tx_tlast;

    stim_t                  stim [TOTAL];
    logic [PACKET_BITS-1:0] pkts [TOTAL];
    logic [PACKET_BITS-1:0] fifo[$];       // Show-ahead FIFO model, head drives dout
    int cycle    = 0;
    int last_pop = -100;
    int pops     = 0;
    int held;
    int tb_errors = 0;
    int exp_sent  = 0;
    int exp_beats = 0;
    int errors, sent, dropped, beats;
    logic busy;

    always #2 user_clk = ~user_clk;  // 4 ns period

    aurora_tx_top uut (.*);

    tx_checker u_checker (.*);

    function automatic logic [3:0] expected_beats(logic [7:0] src, logic [LEN_BITS-1:0] len);
        if (src == TARGET_FPGA_ID || len == '0) return 4'd0;  // Echo or empty packet
        return 4'(len + 2);                                  // Two header words plus payload
    endfunction

    function automatic logic [PACKET_BITS-1:0] build_packet(stim_t s);
        logic [PACKET_BITS-1:0] p;
        for (int i = 0; i < PACKET_WORDS; i++) p[WORD_BITS*i +: WORD_BITS] = $urandom;
        p[BUS_ID_MSB -: 8]  = s.bus_id;
        p[SRC_ID_MSB -: 8]  = s.src_id;
        p[LEN_MSB:LEN_LSB]  = s.len;
        return p;
    endfunction

    // One clock of the FIFO model, pops on rd_en and refreshes empty and dout
    task automatic step();
        @(posedge user_clk);
        cycle++;
        if (rd_en === 1'b1) begin
            if (fifo.size() == 0) begin
                $display("rd_en pulsed at %0t while the FIFO model was empty", $time);
                tb_errors++;
            end else begin
                void'(fifo.pop_front());
                pops++;
                last_pop = cycle;
            end
        end
        empty <= (fifo.size() == 0);
        dout  <= (fifo.size() != 0) ? fifo[0] : '0;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        void'($urandom(32'h5379_3fab));
        reset_TX_RX_Block = 1'b1;
        empty             = 1'b1;
        dout              = '0;
        s_axi_tx_tready   = 1'b0;

        stim[0] = '{8'hA5, 8'h12, 14'd1, 1'b0, 4'd3};  // First sent packet carries seq 0
        stim[1] = '{8'h3C, 8'h34, 14'd6, 1'b0, 4'd8};  // Largest payload
        stim[2] = '{8'h11, 8'h00, 14'd4, 1'b0, 4'd0};  // Source is the target
        stim[3] = '{8'h22, 8'h56, 14'd0, 1'b0, 4'd0};  // Zero length
        stim[4] = '{8'h77, 8'h9A, 14'd2, 1'b1, 4'd4};
        stim[5] = '{8'h0F, 8'h01, 14'd5, 1'b0, 4'd7};
        stim[6] = '{8'hE1, 8'h00, 14'd0, 1'b1, 4'd0};
        stim[7] = '{8'h5A, 8'hC3, 14'd3, 1'b1, 4'd5};
        for (int k = DIRECTED; k < TOTAL; k++) begin
            stim[k].bus_id    = 8'($urandom);
            stim[k].src_id    = 8'($urandom);
            stim[k].len       = ($urandom_range(15, 0) == 0) ? '0 : LEN_BITS'($urandom_range(6, 1));
            stim[k].ready_low = 1'b0;
            stim[k].beats     = expected_beats(stim[k].src_id, stim[k].len);
        end
        for (int k = 0; k < TOTAL; k++) begin
            pkts[k] = build_packet(stim[k]);
            exp_beats += stim[k].beats;
            if (stim[k].beats != 0) exp_sent++;
        end

        repeat (RESET_CYCLES) step();
        reset_TX_RX_Block <= 1'b0;
        s_axi_tx_tready   <= 1'b1;
        repeat (5) step();  // Monitor checks the quiet outputs here

        for (int k = 0; k < TOTAL; k++) begin
            if (stim[k].ready_low) begin
                // Ready may only drop between bursts
                while (fifo.size() != 0 || cycle - last_pop < 14) step();
                s_axi_tx_tready <= 1'b0;
                fifo.push_back(pkts[k]);
                held = pops;
                repeat (8) step();
                if (pops != held) begin
                    $display("rd_en pulsed while tready was held low before packet %0d", k);
                    tb_errors++;
                end
                s_axi_tx_tready <= 1'b1;
            end else begin
                fifo.push_back(pkts[k]);
            end
            step();
        end
        while (fifo.size() != 0 || cycle - last_pop < 20) step();

        if (pops != TOTAL) begin
            $display("Only %0d of %0d packets were popped", pops, TOTAL);
            tb_errors++;
        end
        if (sent != exp_sent || beats != exp_beats || busy) begin
            $display("Totals off: sent %0d of %0d, beats %0d of %0d", sent, exp_sent,
                     beats, exp_beats);
            tb_errors++;
        end
        if (sent <= 256) begin
            $display("Sequence number never wrapped, only %0d packets sent", sent);
            tb_errors++;
        end
        tb_errors += errors;
        $display("Packets %0d, sent %0d, dropped %0d, beats %0d, errors %0d",
                 pops, sent, dropped, beats, tb_errors);
        if (tb_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // Watchdog sized from the packet count
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
rtl/aurora_tx_pkg.sv
rtl/tx_sequencer.sv
rtl/packet_header_regs.sv
rtl/payload_serializer.sv
rtl/aurora_tx_top.sv
tests/tx_checker.sv
tests/tb_aurora_tx.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the Aurora TX serializer testbench with Verilator
set -e

cd "$(dirname "$0")"
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_aurora_tx \
    -f filelist.f

./obj_dir/Vtb_aurora_tx > sim.log 2>&1
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "TB PASSED" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

echo "Simulation finished cleanly"
